//--- Makefile
VERILATOR ?= verilator
TOP       ?= la_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/la_capture_ctrl.sv
// ----------------------------------------------------------------------------
// la_capture_ctrl
// Combines channel hits by AND or OR, stores samples into a circular
// buffer while armed, places the trigger after PRE samples and stops
// once DEPTH-PRE samples from the trigger on have been stored.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module la_capture_ctrl #(
  parameter int NUM_CH = 8,
  parameter int DEPTH  = 64
) (
  input  wire                      sys_clk,
  input  wire                      sys_rst_n,
  input  wire                      i_arm,
  input  wire                      i_arm_start,
  input  wire                      i_tick,
  input  wire  [NUM_CH-1:0]        i_sample,
  input  wire  [NUM_CH-1:0]        i_hit,
  input  wire  [NUM_CH-1:0]        i_enabled,
  input  wire                      i_trig_logic,
  input  wire  [$clog2(DEPTH)-1:0] i_pre,
  input  wire  [$clog2(DEPTH)-1:0] i_buf_raddr,
  output logic [NUM_CH-1:0]        o_buf_rdata,
  output logic                     o_triggered,
  output logic                     o_done,
  output logic [$clog2(DEPTH)-1:0] o_start_idx,
  output logic                     o_finished
);

  localparam int AW = $clog2(DEPTH);

  logic [NUM_CH-1:0] mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] pre_cnt;
  logic [AW:0]   post_cnt;
  logic [AW:0]   post_next;
  logic [AW:0]   post_target;
  logic          hit_and;
  logic          hit_or;
  logic          trig_hit;
  logic          pre_full;
  logic          store;
  logic          trig_now;
  logic          last_store;

  // and needs at least one enabled channel
  assign hit_and  = (&(i_hit | ~i_enabled)) & (|i_enabled);
  assign hit_or   = |(i_hit & i_enabled);
  assign trig_hit = i_trig_logic ? hit_or : hit_and;

  assign pre_full    = (pre_cnt == i_pre);
  assign store       = i_arm & i_tick & ~o_done & ~i_arm_start;
  assign trig_now    = store & ~o_triggered & pre_full & trig_hit;
  assign post_target = (AW + 1)'(DEPTH) - {1'b0, i_pre};

  // trigger sample counts as the first post sample
  assign post_next  = o_triggered ? post_cnt + 1'b1 : (AW + 1)'(1);
  assign last_store = store & (o_triggered | trig_now) & (post_next == post_target);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      wr_ptr      <= '0;
      pre_cnt     <= '0;
      post_cnt    <= '0;
      o_triggered <= 1'b0;
      o_done      <= 1'b0;
      o_start_idx <= '0;
      o_finished  <= 1'b0;
    end else begin
      o_finished <= last_store;
      if (i_arm_start) begin
        wr_ptr      <= '0;
        pre_cnt     <= '0;
        post_cnt    <= '0;
        o_triggered <= 1'b0;
        o_done      <= 1'b0;
      end else if (store) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (!o_triggered && !pre_full) begin
          pre_cnt <= pre_cnt + 1'b1;
        end
        if (trig_now) begin
          o_triggered <= 1'b1;
          // oldest pre-trigger sample, wraps modulo DEPTH
          o_start_idx <= wr_ptr - i_pre;
        end
        if (o_triggered || trig_now) begin
          post_cnt <= post_next;
        end
        if (last_store) begin
          o_done <= 1'b1;
        end
      end
    end
  end

  // sample memory
  always_ff @(posedge sys_clk) begin
    if (store) begin
      mem[wr_ptr] <= i_sample;
    end
  end

  // read port is registered by the register block
  assign o_buf_rdata = mem[i_buf_raddr];

endmodule

`default_nettype wire

//--- design/la_chan_trig.sv
// ----------------------------------------------------------------------------
// la_chan_trig
// Per-channel trigger judge. Compares the current and previous sample
// bit against the channel's mode: level high, rising or falling edge.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module la_chan_trig (
  input  la_pkg::la_trig_mode_e i_mode,
  input  wire                   i_cur,
  input  wire                   i_prev,
  output logic                  o_enabled,
  output logic                  o_hit
);

  import la_pkg::*;

  logic rise;
  logic fall;

  // edges across two consecutive samples
  assign rise = i_cur & ~i_prev;
  assign fall = ~i_cur & i_prev;

  // lets the combiner skip channels that are off
  assign o_enabled = (i_mode != TRIG_OFF);

  always_comb begin
    case (i_mode)
      TRIG_HIGH: o_hit = i_cur;
      TRIG_RISE: o_hit = rise;
      TRIG_FALL: o_hit = fall;
      default:   o_hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/la_pkg.sv
// ----------------------------------------------------------------------------
// la_pkg
// Shared definitions for the logic analyser: ICB widths, register map
// offsets, divider width and per-channel trigger mode codes.
// ----------------------------------------------------------------------------
`default_nettype none

package la_pkg;

  // icb bus widths
  localparam int LA_ADDR_W = 32;
  localparam int LA_DATA_W = 32;

  // offset bits decoded inside the 4 KB peripheral window
  localparam int LA_WIN_W = 12;

  // sample divider field width
  localparam int DIV_W = 8;

  // register map offsets
  localparam logic [LA_WIN_W-1:0] REG_CTRL       = 12'h000;
  localparam logic [LA_WIN_W-1:0] REG_TRIG_MODE  = 12'h004;
  localparam logic [LA_WIN_W-1:0] REG_TRIG_LOGIC = 12'h008;
  localparam logic [LA_WIN_W-1:0] REG_DIV        = 12'h00C;
  localparam logic [LA_WIN_W-1:0] REG_PRE        = 12'h010;
  localparam logic [LA_WIN_W-1:0] REG_STATUS     = 12'h014;
  localparam logic [LA_WIN_W-1:0] REG_START      = 12'h018;

  // capture buffer window, word k at BUF_BASE + 4k
  localparam logic [LA_WIN_W-1:0] BUF_BASE       = 12'h100;

  // status bit positions
  localparam int STAT_ARMED     = 0;
  localparam int STAT_DONE      = 1;
  localparam int STAT_TRIGGERED = 2;

  // per-channel trigger modes, two bits each in REG_TRIG_MODE
  typedef enum logic [1:0] {
    TRIG_OFF  = 2'd0,
    TRIG_HIGH = 2'd1,
    TRIG_RISE = 2'd2,
    TRIG_FALL = 2'd3
  } la_trig_mode_e;

endpackage

`default_nettype wire

//--- design/la_regs.sv
// ----------------------------------------------------------------------------
// la_regs
// ICB slave register block for the logic analyser. Holds arm, trigger
// modes, combine rule, divider and pre-trigger count; returns status, the
// start index and captured buffer words. Arm clears itself when done.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module la_regs #(
  parameter int NUM_CH = 8,
  parameter int DEPTH  = 64
) (
  input  wire                          sys_clk,
  input  wire                          sys_rst_n,
  // icb command
  input  wire                          i_icb_cmd_valid,
  output logic                         o_icb_cmd_ready,
  input  wire  [la_pkg::LA_ADDR_W-1:0] i_icb_cmd_addr,
  input  wire                          i_icb_cmd_read,
  input  wire  [la_pkg::LA_DATA_W-1:0] i_icb_cmd_wdata,
  // icb response
  output logic                         o_icb_rsp_valid,
  input  wire                          i_icb_rsp_ready,
  output logic                         o_icb_rsp_err,
  output logic [la_pkg::LA_DATA_W-1:0] o_icb_rsp_rdata,
  // capture side
  input  wire                          i_finished,
  input  wire                          i_triggered,
  input  wire                          i_done,
  input  wire  [$clog2(DEPTH)-1:0]     i_start_idx,
  input  wire  [NUM_CH-1:0]            i_buf_rdata,
  // control levels
  output logic                         o_arm,
  output logic                         o_arm_start,
  output logic [2*NUM_CH-1:0]          o_trig_mode,
  output logic                         o_trig_logic,
  output logic [la_pkg::DIV_W-1:0]     o_div,
  output logic [$clog2(DEPTH)-1:0]     o_pre,
  output logic [$clog2(DEPTH)-1:0]     o_buf_raddr
);

  import la_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [LA_WIN_W-1:0]  off;
  logic [LA_WIN_W-1:0]  buf_off;
  logic                 is_buf;
  logic                 is_reg;
  logic                 cmd_hsk;
  logic                 wr_en;
  logic [LA_DATA_W-1:0] rd_word;

  assign off     = i_icb_cmd_addr[LA_WIN_W-1:0];
  assign buf_off = off - BUF_BASE;

  // buffer window spans DEPTH aligned words from BUF_BASE
  assign is_buf = (off >= BUF_BASE) && (buf_off < LA_WIN_W'(4 * DEPTH)) &&
                  (off[1:0] == 2'b00);
  assign is_reg = (off == REG_CTRL) || (off == REG_TRIG_MODE) ||
                  (off == REG_TRIG_LOGIC) || (off == REG_DIV) ||
                  (off == REG_PRE) || (off == REG_STATUS) || (off == REG_START);

  assign o_buf_raddr = buf_off[2 +: AW];

  // one response outstanding at a time
  assign o_icb_cmd_ready = ~o_icb_rsp_valid;
  assign cmd_hsk         = i_icb_cmd_valid & o_icb_cmd_ready;
  assign wr_en           = cmd_hsk & ~i_icb_cmd_read;

  // control registers, cpu write beats the self-clear
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      o_arm        <= 1'b0;
      o_arm_start  <= 1'b0;
      o_trig_mode  <= '0;
      o_trig_logic <= 1'b0;
      o_div        <= '0;
      o_pre        <= '0;
    end else begin
      o_arm_start <= 1'b0;
      if (wr_en && off == REG_CTRL) begin
        o_arm       <= i_icb_cmd_wdata[0];
        o_arm_start <= i_icb_cmd_wdata[0];
      end else if (i_finished) begin
        o_arm <= 1'b0;
      end
      if (wr_en) begin
        case (off)
          REG_TRIG_MODE:  o_trig_mode  <= i_icb_cmd_wdata[2*NUM_CH-1:0];
          REG_TRIG_LOGIC: o_trig_logic <= i_icb_cmd_wdata[0];
          REG_DIV:        o_div        <= i_icb_cmd_wdata[DIV_W-1:0];
          REG_PRE:        o_pre        <= i_icb_cmd_wdata[AW-1:0];
          default: ;
        endcase
      end
    end
  end

  // readback mux, buffer word comes straight from memory
  always_comb begin
    rd_word = '0;
    case (off)
      REG_CTRL:       rd_word[0]             = o_arm;
      REG_TRIG_MODE:  rd_word[2*NUM_CH-1:0]  = o_trig_mode;
      REG_TRIG_LOGIC: rd_word[0]             = o_trig_logic;
      REG_DIV:        rd_word[DIV_W-1:0]     = o_div;
      REG_PRE:        rd_word[AW-1:0]        = o_pre;
      REG_STATUS: begin
        rd_word[STAT_ARMED]     = o_arm;
        rd_word[STAT_DONE]      = i_done;
        rd_word[STAT_TRIGGERED] = i_triggered;
      end
      REG_START:      rd_word[AW-1:0]        = i_start_idx;
      default: begin
        if (is_buf) begin
          rd_word[NUM_CH-1:0] = i_buf_rdata;
        end
      end
    endcase
  end

  // response valid holds until the master takes it
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      o_icb_rsp_valid <= 1'b0;
      o_icb_rsp_err   <= 1'b0;
    end else if (cmd_hsk) begin
      o_icb_rsp_valid <= 1'b1;
      o_icb_rsp_err   <= ~(is_reg | is_buf);
    end else if (i_icb_rsp_ready) begin
      o_icb_rsp_valid <= 1'b0;
      o_icb_rsp_err   <= 1'b0;
    end
  end

  // read data captured at acceptance, zero for writes
  always_ff @(posedge sys_clk) begin
    if (cmd_hsk) begin
      o_icb_rsp_rdata <= i_icb_cmd_read ? rd_word : '0;
    end
  end

endmodule

`default_nettype wire

//--- design/la_sample_tick.sv
// ----------------------------------------------------------------------------
// la_sample_tick
// Free-running sample divider. Fires a tick every DIV+1 clocks and
// registers the probe vector together with the tick, keeping the
// previous sample for edge detection.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module la_sample_tick #(
  parameter int NUM_CH = 8
) (
  input  wire                      sys_clk,
  input  wire                      sys_rst_n,
  input  wire  [la_pkg::DIV_W-1:0] i_div,
  input  wire  [NUM_CH-1:0]        i_probe,
  output logic                     o_tick,
  output logic [NUM_CH-1:0]        o_sample,
  output logic [NUM_CH-1:0]        o_prev_sample
);

  import la_pkg::*;

  logic [DIV_W-1:0] cnt;
  logic             cnt_zero;

  assign cnt_zero = (cnt == '0);

  // down-counter, reload on zero
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      cnt    <= '0;
      o_tick <= 1'b0;
    end else begin
      o_tick <= cnt_zero;
      if (cnt_zero) begin
        cnt <= i_div;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // sample and tick rise on the same edge
  always_ff @(posedge sys_clk) begin
    if (cnt_zero) begin
      o_prev_sample <= o_sample;
      o_sample      <= i_probe;
    end
  end

endmodule

`default_nettype wire

//--- design/la_top.sv
// ----------------------------------------------------------------------------
// la_top
// Logic analyser top level: ICB register block, sample tick generator,
// per-channel trigger cells and the capture controller.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module la_top #(
  parameter int NUM_CH = 8,
  parameter int DEPTH  = 64
) (
  input  wire                          sys_clk,
  input  wire                          sys_rst_n,
  input  wire                          i_icb_cmd_valid,
  output logic                         o_icb_cmd_ready,
  input  wire  [la_pkg::LA_ADDR_W-1:0] i_icb_cmd_addr,
  input  wire                          i_icb_cmd_read,
  input  wire  [la_pkg::LA_DATA_W-1:0] i_icb_cmd_wdata,
  output logic                         o_icb_rsp_valid,
  input  wire                          i_icb_rsp_ready,
  output logic                         o_icb_rsp_err,
  output logic [la_pkg::LA_DATA_W-1:0] o_icb_rsp_rdata,
  input  wire  [NUM_CH-1:0]            i_probe
);

  import la_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic                arm;
  logic                arm_start;
  logic [2*NUM_CH-1:0] trig_mode;
  logic                trig_logic;
  logic [DIV_W-1:0]    div;
  logic [AW-1:0]       pre;
  logic [AW-1:0]       buf_raddr;
  logic [NUM_CH-1:0]   buf_rdata;
  logic                triggered;
  logic                done;
  logic [AW-1:0]       start_idx;
  logic                finished;
  logic                tick;
  logic [NUM_CH-1:0]   sample;
  logic [NUM_CH-1:0]   prev_sample;
  logic [NUM_CH-1:0]   hit;
  logic [NUM_CH-1:0]   enabled;

  la_regs #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) u_regs (
    .sys_clk         (sys_clk),
    .sys_rst_n       (sys_rst_n),
    .i_icb_cmd_valid (i_icb_cmd_valid),
    .o_icb_cmd_ready (o_icb_cmd_ready),
    .i_icb_cmd_addr  (i_icb_cmd_addr),
    .i_icb_cmd_read  (i_icb_cmd_read),
    .i_icb_cmd_wdata (i_icb_cmd_wdata),
    .o_icb_rsp_valid (o_icb_rsp_valid),
    .i_icb_rsp_ready (i_icb_rsp_ready),
    .o_icb_rsp_err   (o_icb_rsp_err),
    .o_icb_rsp_rdata (o_icb_rsp_rdata),
    .i_finished      (finished),
    .i_triggered     (triggered),
    .i_done          (done),
    .i_start_idx     (start_idx),
    .i_buf_rdata     (buf_rdata),
    .o_arm           (arm),
    .o_arm_start     (arm_start),
    .o_trig_mode     (trig_mode),
    .o_trig_logic    (trig_logic),
    .o_div           (div),
    .o_pre           (pre),
    .o_buf_raddr     (buf_raddr)
  );

  la_sample_tick #(
    .NUM_CH (NUM_CH)
  ) u_sample_tick (
    .sys_clk       (sys_clk),
    .sys_rst_n     (sys_rst_n),
    .i_div         (div),
    .i_probe       (i_probe),
    .o_tick        (tick),
    .o_sample      (sample),
    .o_prev_sample (prev_sample)
  );

  // one trigger cell per probe channel
  for (genvar g = 0; g < NUM_CH; g++) begin : g_chan
    la_chan_trig u_chan_trig (
      .i_mode    (la_trig_mode_e'(trig_mode[2*g +: 2])),
      .i_cur     (sample[g]),
      .i_prev    (prev_sample[g]),
      .o_enabled (enabled[g]),
      .o_hit     (hit[g])
    );
  end

  la_capture_ctrl #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) u_capture_ctrl (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .i_arm        (arm),
    .i_arm_start  (arm_start),
    .i_tick       (tick),
    .i_sample     (sample),
    .i_hit        (hit),
    .i_enabled    (enabled),
    .i_trig_logic (trig_logic),
    .i_pre        (pre),
    .i_buf_raddr  (buf_raddr),
    .o_buf_rdata  (buf_rdata),
    .o_triggered  (triggered),
    .o_done       (done),
    .o_start_idx  (start_idx),
    .o_finished   (finished)
  );

endmodule

`default_nettype wire

//--- verif/la_tb.sv
// ----------------------------------------------------------------------------
// la_tb
// Testbench for the logic analyser: ICB driver with random response
// back-pressure, probe stimulus, a sample-tick and trigger reference model,
// and assertions on the ICB response channel.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module la_tb;

  import la_pkg::*;

  localparam int NUM_CH    = 8;
  localparam int DEPTH     = 64;
  localparam int LOG_LEN   = 32768;
  localparam int DIV_EDGE  = 3;
  localparam int DIV_AND   = 2;
  localparam int DIV_IDLE  = 1;
  localparam int DIV_SPACE = 4;
  // capture budgets plus slack for register traffic and buffer readout
  localparam int TIMEOUT_CYC = (DIV_EDGE + 1) * DEPTH * 2 + (DIV_AND + 1) * DEPTH * 2 +
                               (DIV_IDLE + 1) * DEPTH * 3 + (DIV_SPACE + 1) * DEPTH * 2 +
                               6000;

  localparam int PROBE_ZERO   = 0;
  localparam int PROBE_TICKS  = 1;
  localparam int PROBE_RANDOM = 2;
  localparam int PROBE_CYCLES = 3;

  logic        sys_clk = 1'b0;
  logic        sys_rst_n;
  logic        icb_cmd_valid;
  logic        icb_cmd_ready;
  logic [31:0] icb_cmd_addr;
  logic        icb_cmd_read;
  logic [31:0] icb_cmd_wdata;
  logic        icb_rsp_valid;
  logic        icb_rsp_ready;
  logic        icb_rsp_err;
  logic [31:0] icb_rsp_rdata;
  logic [7:0]  probe;

  // reference model state
  logic [7:0]  mcnt;
  logic [7:0]  div_m;
  int          tick_no;
  int          arm_first;
  logic [7:0]  sample_log [LOG_LEN];
  logic [31:0] acc_addr;
  logic [31:0] probe_rnd;
  logic [31:0] ready_rnd;
  int          last_tick;
  int          probe_mode;
  int          cycles;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [7:0]  got_words [DEPTH];

  la_top #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) u_la_top (
    .sys_clk         (sys_clk),
    .sys_rst_n       (sys_rst_n),
    .i_icb_cmd_valid (icb_cmd_valid),
    .o_icb_cmd_ready (icb_cmd_ready),
    .i_icb_cmd_addr  (icb_cmd_addr),
    .i_icb_cmd_read  (icb_cmd_read),
    .i_icb_cmd_wdata (icb_cmd_wdata),
    .o_icb_rsp_valid (icb_rsp_valid),
    .i_icb_rsp_ready (icb_rsp_ready),
    .o_icb_rsp_err   (icb_rsp_err),
    .o_icb_rsp_rdata (icb_rsp_rdata),
    .i_probe         (probe)
  );

  always #10 sys_clk = ~sys_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // mapped registers and aligned words of the buffer window
  function automatic logic addr_mapped(input logic [31:0] a);
    logic [11:0] o;
    o = a[11:0];
    if (o == REG_CTRL || o == REG_TRIG_MODE || o == REG_TRIG_LOGIC || o == REG_DIV ||
        o == REG_PRE || o == REG_STATUS || o == REG_START) begin
      return 1'b1;
    end
    return (o >= BUF_BASE) && (o < BUF_BASE + 12'(4 * DEPTH)) && (o[1:0] == 2'b00);
  endfunction

  // tick every DIV+1 cycles with the probe logged at the tick edge
  always @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      mcnt    <= '0;
      div_m   <= '0;
      tick_no <= 0;
    end else begin
      if (mcnt == 8'd0) begin
        mcnt <= div_m;
        if (tick_no < LOG_LEN) begin
          sample_log[tick_no] <= probe;
        end
        tick_no <= tick_no + 1;
      end else begin
        mcnt <= mcnt - 8'd1;
      end
      if (icb_cmd_valid && icb_cmd_ready && !icb_cmd_read) begin
        if (icb_cmd_addr[11:0] == REG_DIV) begin
          div_m <= icb_cmd_wdata[7:0];
        end
        // a tick on the arming edge is not stored
        if (icb_cmd_addr[11:0] == REG_CTRL && icb_cmd_wdata[0]) begin
          arm_first <= (mcnt == 8'd0) ? tick_no + 1 : tick_no;
        end
      end
    end
    if (icb_cmd_valid && icb_cmd_ready) begin
      acc_addr <= icb_cmd_addr;
    end
  end

  // probe changes on the falling edge only
  always @(negedge sys_clk) begin
    case (probe_mode)
      PROBE_TICKS: probe <= tick_no[7:0];
      PROBE_RANDOM: begin
        if (tick_no != last_tick) begin
          probe_rnd = xorshift(probe_rnd);
          probe     <= probe_rnd[7:0];
          last_tick = tick_no;
        end
      end
      PROBE_CYCLES: probe <= probe + 8'd1;
      default: probe <= '0;
    endcase
  end

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation failed");
      $finish;
    end
  end

  a_rsp_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    icb_rsp_valid && !icb_rsp_ready |=>
      icb_rsp_valid && $stable(icb_rsp_rdata) && $stable(icb_rsp_err))
    else begin
      errors++;
      $display("response valid or data changed under back-pressure at %0t", $time);
    end

  a_no_cmd_pending: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    icb_rsp_valid |-> !icb_cmd_ready)
    else begin
      errors++;
      $display("command ready high while a response is pending at %0t", $time);
    end

  a_err_unmapped: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    icb_rsp_valid |-> (icb_rsp_err == !addr_mapped(acc_addr)))
    else begin
      errors++;
      $display("error at %0t: icb_rsp_err got %b expected %b for address %h", $time,
               $sampled(icb_rsp_err), !addr_mapped($sampled(acc_addr)),
               $sampled(acc_addr));
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic icb_access(input logic [31:0] addr, input logic rd, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int   hold;
    logic seen;
    @(negedge sys_clk);
    icb_cmd_valid = 1'b1;
    icb_cmd_addr  = addr;
    icb_cmd_read  = rd;
    icb_cmd_wdata = wdata;
    seen = 1'b0;
    while (!seen) begin
      seen = icb_cmd_ready;
      @(negedge sys_clk);
    end
    icb_cmd_valid = 1'b0;
    // response due in the cycle after acceptance
    check_value("icb_rsp_valid", {31'd0, icb_rsp_valid}, 32'd1);
    ready_rnd = xorshift(ready_rnd);
    hold = int'(ready_rnd[1:0]);
    repeat (hold) @(negedge sys_clk);
    rdata = icb_rsp_rdata;
    err   = icb_rsp_err;
    icb_rsp_ready = 1'b1;
    @(negedge sys_clk);
    icb_rsp_ready = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] off, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    icb_access({20'd0, off}, 1'b0, data, rdata, err);
    check_value("icb_rsp_rdata", rdata, 32'd0);
  endtask

  task automatic read_reg(input logic [11:0] off, output logic [31:0] data);
    logic err;
    icb_access({20'd0, off}, 1'b1, 32'd0, data, err);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // first tick index k >= pre where the combined trigger holds
  function automatic int model_trigger(input int first, input int pre, input logic [15:0] modes,
                                       input logic or_mode, input int last);
    logic [1:0] m;
    logic       cur;
    logic       prv;
    logic       hit;
    logic       any_en;
    logic       all_hit;
    logic       any_hit;
    for (int k = pre; first + k < last; k++) begin
      any_en  = 1'b0;
      all_hit = 1'b1;
      any_hit = 1'b0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        m   = modes[2*ch +: 2];
        cur = sample_log[first + k][ch];
        prv = sample_log[first + k - 1][ch];
        case (m)
          TRIG_HIGH: hit = cur;
          TRIG_RISE: hit = cur & ~prv;
          TRIG_FALL: hit = ~cur & prv;
          default:   hit = 1'b0;
        endcase
        if (m != TRIG_OFF) begin
          any_en  = 1'b1;
          all_hit = all_hit & hit;
          any_hit = any_hit | hit;
        end
      end
      if (or_mode ? any_hit : (any_en & all_hit)) begin
        return k;
      end
    end
    return -1;
  endfunction

  // arm, wait for done, then compare status, start index and buffer
  task automatic run_capture(input logic [15:0] modes, input logic or_mode,
                             input int div, input int pre);
    logic [31:0] v;
    int          k;
    int          start;
    int          idx;
    write_reg(REG_TRIG_MODE, {16'd0, modes});
    write_reg(REG_TRIG_LOGIC, {31'd0, or_mode});
    write_reg(REG_DIV, 32'(div));
    write_reg(REG_PRE, 32'(pre));
    write_reg(REG_CTRL, 32'd1);
    v = '0;
    while (!v[STAT_DONE]) begin
      read_reg(REG_STATUS, v);
    end
    // arm drops one cycle after done rises
    read_reg(REG_STATUS, v);
    check_value("status", v, 32'h6);
    k = model_trigger(arm_first, pre, modes, or_mode, tick_no);
    if (k < 0) begin
      errors++;
      $display("capture finished but the model saw no trigger");
    end else begin
      start = (k - pre) % DEPTH;
      read_reg(REG_START, v);
      check_value("start_idx", v, 32'(start));
      for (int j = 0; j < DEPTH; j++) begin
        idx = (start + j) % DEPTH;
        read_reg(BUF_BASE + 12'(4 * idx), v);
        got_words[j] = v[7:0];
        check_value($sformatf("buf[%0d]", idx), v,
                    {24'd0, sample_log[arm_first + k - pre + j]});
      end
    end
  endtask

  initial begin
    logic [31:0] v;
    logic        err;
    int          errs0;
    sys_rst_n     = 1'b0;
    icb_cmd_valid = 1'b0;
    icb_cmd_addr  = '0;
    icb_cmd_read  = 1'b0;
    icb_cmd_wdata = '0;
    icb_rsp_ready = 1'b0;
    probe         = '0;
    probe_mode    = PROBE_ZERO;
    probe_rnd     = 32'hfd848d3e;
    ready_rnd     = xorshift(32'hfd848d3e);
    last_tick     = -1;
    arm_first     = 0;
    acc_addr      = '0;
    cycles        = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (2) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_n = 1'b1;

    // register readback and unmapped access
    errs0 = errors;
    read_reg(REG_CTRL, v);
    check_value("ctrl", v, 32'd0);
    read_reg(REG_TRIG_MODE, v);
    check_value("trig_mode", v, 32'd0);
    read_reg(REG_TRIG_LOGIC, v);
    check_value("trig_logic", v, 32'd0);
    read_reg(REG_DIV, v);
    check_value("div", v, 32'd0);
    read_reg(REG_PRE, v);
    check_value("pre", v, 32'd0);
    read_reg(REG_STATUS, v);
    check_value("status", v, 32'd0);
    read_reg(REG_START, v);
    check_value("start", v, 32'd0);
    write_reg(REG_TRIG_MODE, 32'h0000a5c3);
    write_reg(REG_TRIG_LOGIC, 32'd1);
    write_reg(REG_DIV, 32'h15a);
    write_reg(REG_PRE, 32'heb);
    read_reg(REG_TRIG_MODE, v);
    check_value("trig_mode", v, 32'h0000a5c3);
    read_reg(REG_TRIG_LOGIC, v);
    check_value("trig_logic", v, 32'd1);
    read_reg(REG_DIV, v);
    check_value("div", v, 32'h5a);
    read_reg(REG_PRE, v);
    check_value("pre", v, 32'h2b);
    icb_access(32'h20, 1'b1, 32'd0, v, err);
    check_value("icb_rsp_err", {31'd0, err}, 32'd1);
    icb_access(32'h200, 1'b1, 32'd0, v, err);
    check_value("icb_rsp_err", {31'd0, err}, 32'd1);
    report_test("register_readback", errs0);

    // a second command waits on the bus while the response is held
    errs0 = errors;
    @(negedge sys_clk);
    icb_cmd_valid = 1'b1;
    icb_cmd_addr  = {20'd0, REG_DIV};
    icb_cmd_read  = 1'b1;
    while (!icb_cmd_ready) @(negedge sys_clk);
    @(negedge sys_clk);
    icb_cmd_addr  = {20'd0, REG_PRE};
    icb_cmd_read  = 1'b0;
    icb_cmd_wdata = 32'd9;
    repeat (6) begin
      check_value("icb_cmd_ready", {31'd0, icb_cmd_ready}, 32'd0);
      check_value("icb_rsp_rdata", icb_rsp_rdata, 32'h5a);
      @(negedge sys_clk);
    end
    icb_cmd_valid = 1'b0;
    icb_rsp_ready = 1'b1;
    @(negedge sys_clk);
    icb_rsp_ready = 1'b0;
    read_reg(REG_PRE, v);
    check_value("pre", v, 32'h2b);
    report_test("response_backpressure", errs0);

    // channel 3 rising edge in or mode
    errs0 = errors;
    probe_mode = PROBE_TICKS;
    run_capture(16'h0080, 1'b1, DIV_EDGE, 8);
    report_test("rise_or_capture", errs0);

    // channel 0 high and channel 5 falling in and mode
    errs0 = errors;
    probe_mode = PROBE_RANDOM;
    run_capture(16'h0c01, 1'b0, DIV_AND, 12);
    report_test("and_capture", errs0);

    // nothing enabled so capture stays armed
    errs0 = errors;
    write_reg(REG_TRIG_MODE, 32'd0);
    write_reg(REG_TRIG_LOGIC, 32'd0);
    write_reg(REG_DIV, 32'(DIV_IDLE));
    write_reg(REG_CTRL, 32'd1);
    v = 32'(tick_no + DEPTH * 3);
    while (tick_no < int'(v)) @(negedge sys_clk);
    read_reg(REG_STATUS, v);
    check_value("status", v, 32'h1);
    write_reg(REG_CTRL, 32'd0);
    report_test("no_trigger", errs0);

    // counter probe shows the tick spacing
    errs0 = errors;
    probe_mode = PROBE_CYCLES;
    run_capture(16'h0001, 1'b1, DIV_SPACE, 0);
    for (int j = 1; j < DEPTH; j++) begin
      check_value("sample_step", {24'd0, 8'(got_words[j] - got_words[j-1])},
                  32'(DIV_SPACE + 1));
    end
    report_test("divider_spacing", errs0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/la_pkg.sv
design/la_regs.sv
design/la_sample_tick.sv
design/la_chan_trig.sv
design/la_capture_ctrl.sv
design/la_top.sv
verif/la_tb.sv
